//--- fetch_pkg.sv
// Front-end configuration and the records passed between fetch and decode
// reset vector, queue sizing, bus byte order, queue entry and redirect
`default_nettype none

package fetch_pkg;

  // start address after reset and while halted
  localparam rv32i_types_pkg::word_t RESET_PC = 32'h80000000;

  // fetch queue sizing
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  // count needs to hold QUEUE_DEPTH itself
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  // 0 means the bus is little endian and fetch swaps bytes
  localparam logic BUS_BIG_ENDIAN = 1'b0;

  // one fetched word, 97 bits
  typedef struct packed {
    rv32i_types_pkg::word_t pc;
    rv32i_types_pkg::word_t pc4;
    rv32i_types_pkg::word_t instr;
    // fetch address had nonzero low bits
    logic                   mal_insn;
  } fetch_entry_t;

  // late pipeline correction
  typedef struct packed {
    logic                   valid;
    rv32i_types_pkg::word_t target;
  } redirect_t;

endpackage

`default_nettype wire

//--- fetch_queue.sv
// Fetch queue between fetch and decode
// circular buffer of fetch entries with occupancy count and one-cycle flush
`timescale 1ns/1ns
`default_nettype none

module fetch_queue (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    flush,
  input  logic                    push,
  input  fetch_pkg::fetch_entry_t wdata,
  input  logic                    pop,
  output logic                    full,
  output logic                    empty,
  output fetch_pkg::fetch_entry_t rdata
);

  fetch_pkg::fetch_entry_t         mem [fetch_pkg::QUEUE_DEPTH];
  logic [fetch_pkg::QPTR_W-1:0]    wr_ptr;
  logic [fetch_pkg::QPTR_W-1:0]    rd_ptr;
  logic [fetch_pkg::QCNT_W-1:0]    count;
  logic                            do_push;
  logic                            do_pop;

  // pointer advance with wrap at the last slot
  function automatic logic [fetch_pkg::QPTR_W-1:0] ptr_inc(
    input logic [fetch_pkg::QPTR_W-1:0] p
  );
    if (p == fetch_pkg::QPTR_W'(fetch_pkg::QUEUE_DEPTH - 1)) begin
      ptr_inc = '0;
    end else begin
      ptr_inc = p + 1'b1;
    end
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == fetch_pkg::QCNT_W'(fetch_pkg::QUEUE_DEPTH));
  // head entry, valid while not empty
  assign rdata   = mem[rd_ptr];

  // flush overrides both sides
  assign do_push = push & ~flush;
  assign do_pop  = pop & ~flush;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // count moves only when one side acts alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // fetch must hold its entry while the queue is full
  a_no_push_full : assert property (
    @(posedge CLK) disable iff (!nRST)
    push |-> !full
  ) else $error("push into full fetch queue");

  // decoder must not pop an empty queue
  a_no_pop_empty : assert property (
    @(posedge CLK) disable iff (!nRST)
    pop |-> !empty
  ) else $error("pop from empty fetch queue");

endmodule

`default_nettype wire

//--- instr_decoder.sv
// Instruction decoder
// pops the queue head, splits the word into fields, class and immediate,
// and presents one registered decoded instruction per pop
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      flush,
  input  logic                      empty,
  input  fetch_pkg::fetch_entry_t   entry,
  output logic                      pop,
  output logic                      dec_valid,
  output rv32i_types_pkg::decoded_t decoded
);

  rv32i_types_pkg::word_t    instr;
  rv32i_types_pkg::opcode_t  opcode;
  rv32i_types_pkg::op_class_t op_class;
  rv32i_types_pkg::imm_fmt_t imm_fmt;
  rv32i_types_pkg::word_t    imm;

  // decoder never stalls
  assign pop    = ~empty;

  assign instr  = entry.instr;
  assign opcode = instr[6:0];

  // opcode to class and immediate layout
  always_comb begin
    op_class = rv32i_types_pkg::ILLEGAL;
    imm_fmt  = rv32i_types_pkg::FMT_NONE;
    case (opcode)
      rv32i_types_pkg::OPC_LUI, rv32i_types_pkg::OPC_AUIPC: begin
        op_class = rv32i_types_pkg::UPPER;
        imm_fmt  = rv32i_types_pkg::FMT_U;
      end
      rv32i_types_pkg::OPC_JAL: begin
        op_class = rv32i_types_pkg::JUMP;
        imm_fmt  = rv32i_types_pkg::FMT_J;
      end
      rv32i_types_pkg::OPC_JALR: begin
        // register indirect jump uses the I layout
        op_class = rv32i_types_pkg::JUMP;
        imm_fmt  = rv32i_types_pkg::FMT_I;
      end
      rv32i_types_pkg::OPC_BRANCH: begin
        op_class = rv32i_types_pkg::BRANCH;
        imm_fmt  = rv32i_types_pkg::FMT_B;
      end
      rv32i_types_pkg::OPC_LOAD: begin
        op_class = rv32i_types_pkg::LOAD;
        imm_fmt  = rv32i_types_pkg::FMT_I;
      end
      rv32i_types_pkg::OPC_STORE: begin
        op_class = rv32i_types_pkg::STORE;
        imm_fmt  = rv32i_types_pkg::FMT_S;
      end
      rv32i_types_pkg::OPC_IMM: begin
        op_class = rv32i_types_pkg::ALU_IMM;
        imm_fmt  = rv32i_types_pkg::FMT_I;
      end
      rv32i_types_pkg::OPC_REG: begin
        // no immediate for register ops
        op_class = rv32i_types_pkg::ALU_REG;
      end
      default: begin
        op_class = rv32i_types_pkg::ILLEGAL;
      end
    endcase
  end

  // immediate assembly, sign taken from bit 31 throughout
  always_comb begin
    case (imm_fmt)
      rv32i_types_pkg::FMT_I: imm = {{20{instr[31]}}, instr[31:20]};
      rv32i_types_pkg::FMT_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv32i_types_pkg::FMT_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
      rv32i_types_pkg::FMT_U: imm = {instr[31:12], 12'h000};
      rv32i_types_pkg::FMT_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
      default:                imm = '0;
    endcase
  end

  // output strobe, one cycle per pop
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= pop & ~flush;
    end
  end

  // decoded payload
  always_ff @(posedge CLK) begin
    if (flush) begin
      decoded <= '0;
    end else if (pop) begin
      decoded.pc       <= entry.pc;
      decoded.op_class <= op_class;
      decoded.rd       <= instr[11:7];
      decoded.rs1      <= instr[19:15];
      decoded.rs2      <= instr[24:20];
      decoded.funct3   <= instr[14:12];
      decoded.funct7   <= instr[31:25];
      decoded.imm      <= imm;
      decoded.mal_insn <= entry.mal_insn;
    end
  end

endmodule

`default_nettype wire

//--- ooo_fetch_stage.sv
// Fetch stage of the front end
// keeps the pc, drives the instruction read bus and registers each
// accepted word into an entry that is pushed into the fetch queue
`timescale 1ns/1ns
`default_nettype none

module ooo_fetch_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    halt,
  input  fetch_pkg::redirect_t    redirect,
  input  rv32i_types_pkg::word_t  rdata,
  input  logic                    busy,
  input  logic                    full,
  output rv32i_types_pkg::word_t  addr,
  output logic                    ren,
  output logic                    push,
  output fetch_pkg::fetch_entry_t entry
);

  rv32i_types_pkg::word_t pc;
  rv32i_types_pkg::word_t pc4;
  rv32i_types_pkg::word_t next_pc;
  rv32i_types_pkg::word_t instr;
  logic                   accept;
  logic                   mal_addr;
  logic                   entry_valid;

  // reverse byte order of a bus word
  function automatic rv32i_types_pkg::word_t byte_swap(input rv32i_types_pkg::word_t w);
    byte_swap = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign pc4      = pc + 32'd4;
  assign addr     = pc;
  assign mal_addr = (pc[1:0] != 2'b00);

  // no read in reset, during halt or redirect, or with the queue full
  assign ren    = nRST & ~halt & ~redirect.valid & ~full;
  // word is taken on the edge where busy is low
  assign accept = ren & ~busy;

  // put the word in instruction order
  assign instr = fetch_pkg::BUS_BIG_ENDIAN ? rdata : byte_swap(rdata);

  // next pc priority
  // halt, then redirect, then sequential on accept, else hold
  always_comb begin
    if (halt) begin
      next_pc = fetch_pkg::RESET_PC;
    end else if (redirect.valid) begin
      next_pc = redirect.target;
    end else if (accept) begin
      next_pc = pc4;
    end else begin
      next_pc = pc;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= fetch_pkg::RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // entry stays valid until the queue takes it
  // strobe is dropped on the edge of a redirect or halt
  assign push = entry_valid & ~full & ~redirect.valid & ~halt;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      entry_valid <= 1'b0;
    end else if (halt || redirect.valid) begin
      entry_valid <= 1'b0;
    end else if (accept) begin
      // accept implies room, so an old entry leaves on this same edge
      entry_valid <= 1'b1;
    end else if (push) begin
      entry_valid <= 1'b0;
    end
  end

  // payload of the entry
  always_ff @(posedge CLK) begin
    if (accept) begin
      entry.pc       <= pc;
      entry.pc4      <= pc4;
      entry.instr    <= instr;
      entry.mal_insn <= mal_addr;
    end
  end

  // halted fetch is quiet and parks the pc on the reset vector
  a_halt_parks_pc : assert property (
    @(posedge CLK) disable iff (!nRST)
    halt |-> !ren && !push ##1 (addr == fetch_pkg::RESET_PC)
  ) else $error("fetch active or pc not parked during halt");

endmodule

`default_nettype wire

//--- ooo_front_end.f
rv32i_types_pkg.sv
fetch_pkg.sv
ooo_fetch_stage.sv
fetch_queue.sv
instr_decoder.sv
ooo_front_end.sv
tb_front_end_checker.sv
tb_front_end.sv

//--- ooo_front_end.sv
// Instruction front end top level
// fetch stage feeding the fetch queue, drained by the decoder
`timescale 1ns/1ns
`default_nettype none

module ooo_front_end (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      halt,
  input  fetch_pkg::redirect_t      redirect,
  input  rv32i_types_pkg::word_t    rdata,
  input  logic                      busy,
  output rv32i_types_pkg::word_t    addr,
  output logic                      ren,
  output logic                      dec_valid,
  output rv32i_types_pkg::decoded_t decoded
);

  fetch_pkg::fetch_entry_t push_entry;
  fetch_pkg::fetch_entry_t head_entry;
  logic                    push;
  logic                    pop;
  logic                    full;
  logic                    empty;
  logic                    flush;

  // redirect and halt both drop everything past the pc
  assign flush = redirect.valid | halt;

  ooo_fetch_stage i_fetch (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .redirect (redirect),
    .rdata    (rdata),
    .busy     (busy),
    .full     (full),
    .addr     (addr),
    .ren      (ren),
    .push     (push),
    .entry    (push_entry)
  );

  fetch_queue i_queue (
    .CLK   (CLK),
    .nRST  (nRST),
    .flush (flush),
    .push  (push),
    .wdata (push_entry),
    .pop   (pop),
    .full  (full),
    .empty (empty),
    .rdata (head_entry)
  );

  instr_decoder i_decoder (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .empty     (empty),
    .entry     (head_entry),
    .pop       (pop),
    .dec_valid (dec_valid),
    .decoded   (decoded)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_front_end -f ooo_front_end.f -o sim_front_end

./obj_dir/sim_front_end > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -qx "Finished with no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation PASSED"

//--- rv32i_types_pkg.sv
// RV32I base types shared by the front end
// word type, major opcodes, operation classes and the decoded instruction record
`default_nettype none

package rv32i_types_pkg;

  // basic data word
  typedef logic [31:0] word_t;

  // major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_IMM    = 7'b0010011;
  localparam opcode_t OPC_REG    = 7'b0110011;

  // coarse class handed to the back end
  typedef enum logic [2:0] {
    ALU_REG,
    ALU_IMM,
    LOAD,
    STORE,
    BRANCH,
    JUMP,
    UPPER,
    ILLEGAL
  } op_class_t;

  // immediate layouts of the base ISA
  // FMT_NONE gives a zero immediate (register ops, illegal)
  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J
  } imm_fmt_t;

  // one decoded instruction, about 100 bits
  typedef struct packed {
    word_t       pc;
    op_class_t   op_class;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    // sign extended
    word_t       imm;
    logic        mal_insn;
  } decoded_t;

endpackage

`default_nettype wire

//--- tb_front_end.sv
// Testbench for the instruction front end
// clocks the DUT, models the instruction memory with random busy,
// and drives random redirects and two halt pulses
`timescale 1ns/1ns
`default_nettype none

module tb_front_end;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 8;
  localparam int RUN_CYCLES    = 3000;
  localparam int MARGIN_CYCLES = 200;
  localparam int TIMEOUT_NS    = (RUN_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic                      CLK;
  logic                      nRST;
  logic                      halt;
  fetch_pkg::redirect_t      redirect;
  rv32i_types_pkg::word_t    rdata;
  logic                      busy;
  rv32i_types_pkg::word_t    addr;
  logic                      ren;
  logic                      dec_valid;
  rv32i_types_pkg::decoded_t decoded;
  logic                      done;
  int                        errors;

  // instruction memory, one word per addr[9:2]
  rv32i_types_pkg::word_t mem [256];
  logic [31:0]            lcg_state;
  // busy countdown of the read in progress
  rv32i_types_pkg::word_t last_addr;
  logic                   addr_seen;
  int                     wait_left;

  ooo_front_end i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .redirect  (redirect),
    .rdata     (rdata),
    .busy      (busy),
    .addr      (addr),
    .ren       (ren),
    .dec_valid (dec_valid),
    .decoded   (decoded)
  );

  tb_front_end_checker i_check (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .redirect  (redirect),
    .addr      (addr),
    .ren       (ren),
    .busy      (busy),
    .dec_valid (dec_valid),
    .decoded   (decoded),
    .mem_words (mem),
    .done      (done),
    .errors    (errors)
  );

  // 32-bit LCG
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    next_rand = lcg_state;
  endfunction

  function automatic rv32i_types_pkg::opcode_t legal_opcode(input int unsigned k);
    case (k % 9)
      0:       legal_opcode = rv32i_types_pkg::OPC_LUI;
      1:       legal_opcode = rv32i_types_pkg::OPC_AUIPC;
      2:       legal_opcode = rv32i_types_pkg::OPC_JAL;
      3:       legal_opcode = rv32i_types_pkg::OPC_JALR;
      4:       legal_opcode = rv32i_types_pkg::OPC_BRANCH;
      5:       legal_opcode = rv32i_types_pkg::OPC_LOAD;
      6:       legal_opcode = rv32i_types_pkg::OPC_STORE;
      7:       legal_opcode = rv32i_types_pkg::OPC_IMM;
      default: legal_opcode = rv32i_types_pkg::OPC_REG;
    endcase
  endfunction

  // little endian bus hands the bytes over reversed
  function automatic rv32i_types_pkg::word_t bus_order(input rv32i_types_pkg::word_t w);
    if (fetch_pkg::BUS_BIG_ENDIAN) begin
      bus_order = w;
    end else begin
      bus_order = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
  endfunction

  // memory answer for the current address
  task automatic drive_memory();
    logic [31:0] r;
    if (!addr_seen || addr != last_addr) begin
      // new read, 0 to 3 busy cycles
      r         = next_rand();
      wait_left = int'(r[25:24]);
      last_addr = addr;
      addr_seen = 1'b1;
    end else if (wait_left > 0) begin
      wait_left = wait_left - 1;
    end
    busy  = (wait_left != 0);
    rdata = bus_order(mem[addr[9:2]]);
  endtask

  // halt windows and random redirects
  task automatic drive_control(input int cyc);
    logic [31:0] r;
    logic [31:0] t;
    int unsigned pick;
    redirect = '0;
    halt     = (cyc >= 1000 && cyc < 1006) || (cyc >= 2000 && cyc < 2004);
    r        = next_rand();
    pick     = r >> 8;
    if (!halt && pick % 40 == 0) begin
      t               = next_rand();
      redirect.valid  = 1'b1;
      // mostly aligned, now and then a misaligned target
      redirect.target = {fetch_pkg::RESET_PC[31:10], t[9:2],
                         (t[28:26] == 3'b000) ? t[1:0] : 2'b00};
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the run reached its end");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    nRST      = 1'b0;
    halt      = 1'b0;
    redirect  = '0;
    rdata     = '0;
    busy      = 1'b0;
    done      = 1'b0;
    lcg_state = 32'd77873;
    addr_seen = 1'b0;
    wait_left = 0;
    last_addr = '0;
    for (int i = 0; i < 256; i++) begin
      r = next_rand();
      w = next_rand();
      // 90% legal opcodes, the rest stay random
      if (r % 10 != 0) begin
        w[6:0] = legal_opcode(r >> 4);
      end
      mem[i] = w;
    end
    repeat (RESET_CYCLES) begin
      @(negedge CLK);
      drive_memory();
    end
    nRST = 1'b1;
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(negedge CLK);
      drive_memory();
      drive_control(cyc);
    end
    // drain, halt drops whatever is in flight
    @(negedge CLK);
    drive_memory();
    redirect = '0;
    halt     = 1'b1;
    repeat (4) begin
      @(negedge CLK);
      drive_memory();
    end
    done = 1'b1;
    // checker reports on the rising edge in between
    @(negedge CLK);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_front_end_checker.sv
// Checker for the instruction front end
// follows the pc stream, counts reads at the bus and decodes the
// memory word behind every output on its own
`timescale 1ns/1ns
`default_nettype none

module tb_front_end_checker (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      halt,
  input  fetch_pkg::redirect_t      redirect,
  input  rv32i_types_pkg::word_t    addr,
  input  logic                      ren,
  input  logic                      busy,
  input  logic                      dec_valid,
  input  rv32i_types_pkg::decoded_t decoded,
  input  rv32i_types_pkg::word_t    mem_words [256],
  input  logic                      done,
  output int                        errors
);

  // next pc expected at dec_valid
  rv32i_types_pkg::word_t exp_pc = fetch_pkg::RESET_PC;
  // first bus address after reset, halt or redirect
  rv32i_types_pkg::word_t fetch_start = fetch_pkg::RESET_PC;
  logic check_start = 1'b1;
  logic seen_accept = 1'b0;
  logic flush_prev  = 1'b0;
  logic reported    = 1'b0;
  int   in_flight   = 0;
  int   accepted    = 0;
  int   discarded   = 0;
  int   dec_count   = 0;
  int   err_count   = 0;

  assign errors = err_count;

  task automatic report_error(input string msg);
    err_count = err_count + 1;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // sign extend the low bits of v
  function automatic rv32i_types_pkg::word_t sign_extend(input rv32i_types_pkg::word_t v,
                                                         input int bits);
    rv32i_types_pkg::word_t shl;
    shl         = v << (32 - bits);
    sign_extend = $signed(shl) >>> (32 - bits);
  endfunction

  function automatic rv32i_types_pkg::decoded_t expected_decode(
    input rv32i_types_pkg::word_t pc,
    input rv32i_types_pkg::word_t w
  );
    rv32i_types_pkg::decoded_t d;
    d          = '0;
    d.pc       = pc;
    d.rd       = w[11:7];
    d.rs1      = w[19:15];
    d.rs2      = w[24:20];
    d.funct3   = w[14:12];
    d.funct7   = w[31:25];
    d.mal_insn = (pc[1:0] != 2'b00);
    d.op_class = rv32i_types_pkg::ILLEGAL;
    case (w[6:0])
      rv32i_types_pkg::OPC_REG: d.op_class = rv32i_types_pkg::ALU_REG;
      rv32i_types_pkg::OPC_IMM: begin
        d.op_class = rv32i_types_pkg::ALU_IMM;
        d.imm      = sign_extend(w >> 20, 12);
      end
      rv32i_types_pkg::OPC_LOAD: begin
        d.op_class = rv32i_types_pkg::LOAD;
        d.imm      = sign_extend(w >> 20, 12);
      end
      rv32i_types_pkg::OPC_JALR: begin
        d.op_class = rv32i_types_pkg::JUMP;
        d.imm      = sign_extend(w >> 20, 12);
      end
      rv32i_types_pkg::OPC_STORE: begin
        d.op_class = rv32i_types_pkg::STORE;
        d.imm      = sign_extend(32'({w[31:25], w[11:7]}), 12);
      end
      rv32i_types_pkg::OPC_BRANCH: begin
        d.op_class = rv32i_types_pkg::BRANCH;
        d.imm      = sign_extend(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
      end
      rv32i_types_pkg::OPC_JAL: begin
        d.op_class = rv32i_types_pkg::JUMP;
        d.imm      = sign_extend(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
      end
      rv32i_types_pkg::OPC_LUI, rv32i_types_pkg::OPC_AUIPC: begin
        d.op_class = rv32i_types_pkg::UPPER;
        d.imm      = w & 32'hFFFFF000;
      end
      default: d.op_class = rv32i_types_pkg::ILLEGAL;
    endcase
    expected_decode = d;
  endfunction

  task automatic compare_decode();
    rv32i_types_pkg::decoded_t exp;
    // memory is word indexed, low pc bits do not select
    exp = expected_decode(exp_pc, mem_words[exp_pc[9:2]]);
    if (decoded !== exp) begin
      report_error($sformatf("got pc %h class %0d imm %h regs %0d %0d %0d mal %b, %s %h %0d %h",
                             decoded.pc, decoded.op_class, decoded.imm, decoded.rd,
                             decoded.rs1, decoded.rs2, decoded.mal_insn,
                             "expected pc class imm", exp.pc, exp.op_class, exp.imm));
    end
  endtask

  task automatic final_report();
    if (in_flight != 0) begin
      report_error($sformatf("%0d reads still in flight at the end", in_flight));
    end
    if (dec_count != accepted - discarded) begin
      report_error($sformatf("decoded %0d instructions, expected %0d",
                             dec_count, accepted - discarded));
    end
    $display("checker: %0d decoded, %0d reads accepted, %0d discarded, %0d errors",
             dec_count, accepted, discarded, err_count);
  endtask

  // sampled on the rising edge, before any register updates
  always @(posedge CLK) begin
    if (!nRST) begin
      exp_pc      = fetch_pkg::RESET_PC;
      fetch_start = fetch_pkg::RESET_PC;
      check_start = 1'b1;
      in_flight   = 0;
      flush_prev  = 1'b0;
      if (dec_valid) begin
        report_error("dec_valid high during reset");
      end
      if (ren) begin
        report_error("ren high during reset");
      end
    end else begin
      // output side first, a strobe seen on a flush edge is still valid
      if (dec_valid) begin
        if (!seen_accept) begin
          report_error("dec_valid before the first accepted read");
        end
        if (flush_prev) begin
          report_error("stale instruction right after redirect or halt");
        end
        if (in_flight == 0) begin
          report_error("dec_valid with no accepted read outstanding");
        end else begin
          in_flight = in_flight - 1;
        end
        dec_count = dec_count + 1;
        compare_decode();
        exp_pc = exp_pc + 32'd4;
      end
      if (ren && (halt || redirect.valid)) begin
        report_error("read requested during halt or redirect");
      end
      // halt wins over redirect
      if (halt || redirect.valid) begin
        discarded   = discarded + in_flight;
        in_flight   = 0;
        exp_pc      = halt ? fetch_pkg::RESET_PC : redirect.target;
        fetch_start = exp_pc;
        check_start = 1'b1;
      end
      // bus side
      if (ren && !busy) begin
        if (check_start && addr != fetch_start) begin
          report_error($sformatf("first read at %h, expected %h", addr, fetch_start));
        end
        check_start = 1'b0;
        seen_accept = 1'b1;
        accepted    = accepted + 1;
        in_flight   = in_flight + 1;
      end
      flush_prev = halt || redirect.valid;
    end
    if (done && !reported) begin
      reported = 1'b1;
      final_report();
    end
  end

endmodule

`default_nettype wire
